//--- compile.f
source/core_pkg.sv
source/axi_pkg.sv
source/fetch_unit.sv
source/insn_queue.sv
source/reg_file.sv
source/execute_unit.sv
source/core_top.sv
test/core_asserts.sv
test/core_tb.sv

//--- Bender.yml
package:
  name: core_pipeline

sources:
  - source/core_pkg.sv
  - source/axi_pkg.sv
  - source/fetch_unit.sv
  - source/insn_queue.sv
  - source/reg_file.sv
  - source/execute_unit.sv
  - source/core_top.sv
  - target: test
    files:
      - test/core_asserts.sv
      - test/core_tb.sv

//--- test/core_tb.sv
`timescale 1ns/10ps

module core_tb;

	localparam int clk_period = 40; // ns
	localparam int num_retires = 400; // Run length

	logic clk = 1'b0;
	logic rst_n;
	logic ar_valid;
	core_pkg::addr_t ar_addr;
	logic ar_ready;
	logic r_valid;
	core_pkg::word_t r_data;
	axi_pkg::resp_t r_resp;
	logic r_ready;
	logic retire_valid;
	core_pkg::addr_t retire_pc;
	core_pkg::reg_idx_t retire_reg;
	core_pkg::word_t retire_data;

	logic [15:0] lfsr = 16'd39; // Seed
	core_pkg::word_t mem [0:63]; // Program image, wraps every 256 bytes
	logic err_flag [0:63]; // Word answered with SLVERR or DECERR
	logic [3:0] kept_ops [0:5] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'hc, 4'hd}; // AND EOR SUB ADD ORR MOV
	core_pkg::addr_t ar_pending [$]; // Accepted reads, oldest first
	core_pkg::word_t model_regs [0:15] = '{default: '0};
	core_pkg::addr_t model_pc = core_pkg::reset_pc;
	core_pkg::addr_t exp_pc; // Next expected retire
	core_pkg::reg_idx_t exp_reg;
	core_pkg::word_t exp_data;
	logic first_ar = 1'b1;
	logic resp_done;
	int errors = 0;
	int retire_count = 0;

	core_top dut0 (.*);

	always #(clk_period / 2) clk = ~clk;

	// x^16 + x^15 + x^13 + x^4 + 1, one step per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_word(string name, core_pkg::word_t exp, core_pkg::word_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(string name, core_pkg::addr_t exp, core_pkg::addr_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_reg(string name, core_pkg::reg_idx_t exp, core_pkg::reg_idx_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Mostly data processing on r0..r7, some branches and other encodings
	task automatic gen_program();
		core_pkg::word_t r;
		logic [2:0] kind;
		logic [3:0] opc;
		logic [3:0] rot;
		logic [31:0] off;
		for (int i = 0; i < 64; i++) begin
			r = next_bits(32); // Raw fields
			kind = 3'(next_bits(3));
			opc = kept_ops[next_bits(3) % 6];
			rot = (next_bits(2) == 0) ? r[11:8] : 4'h0; // Mostly unrotated
			off = next_bits(3) - 1; // -1 to 6 words, never back onto itself
			err_flag[i] = (next_bits(4) == 0);
			if (kind == 3'd0)
				mem[i] = {r[31:28], 3'b101, r[24], off[23:0]};
			else if (kind == 3'd1)
				mem[i] = {r[31:28], r[27], 1'b1, r[25:0]}; // Load/store or coprocessor
			else
				mem[i] = {r[31:28], 2'b00, r[25] | r[26], opc, r[20], 1'b0, r[18:16], 1'b0,
					r[14:12], (r[25] | r[26]) ? {rot, r[7:0]} : {r[11:4], 1'b0, r[2:0]}};
		end
	endtask

	// Steps the program until the next retiring instruction
	task automatic model_next();
		core_pkg::word_t w;
		core_pkg::word_t b;
		logic [3:0] opc;
		int amt;
		logic found;
		found = 1'b0;
		for (int steps = 0; steps < 1000 && !found; steps++) begin
			w = mem[model_pc[7:2]];
			opc = w[24:21];
			if (err_flag[model_pc[7:2]]) begin
				model_pc = model_pc + 32'd4; // Error response acts as a no-op
			end else if (w[27:26] == 2'b00 && opc inside {4'h0, 4'h1, 4'h2, 4'h4, 4'hc, 4'hd}) begin
				amt = 2 * w[11:8];
				if (w[25])
					b = ({24'b0, w[7:0]} >> amt) | ({24'b0, w[7:0]} << (32 - amt));
				else
					b = model_regs[w[3:0]]; // Rm, bits 11:4 ignored
				case (opc)
					4'h0: exp_data = model_regs[w[19:16]] & b;
					4'h1: exp_data = model_regs[w[19:16]] ^ b;
					4'h2: exp_data = model_regs[w[19:16]] - b;
					4'h4: exp_data = model_regs[w[19:16]] + b;
					4'hc: exp_data = model_regs[w[19:16]] | b;
					default: exp_data = b; // MOV
				endcase
				model_regs[w[15:12]] = exp_data;
				exp_pc = model_pc;
				exp_reg = w[15:12];
				found = 1'b1;
				model_pc = model_pc + 32'd4;
			end else if (w[27:25] == 3'b101) begin
				model_pc = model_pc + 32'd8 + {{6{w[23]}}, w[23:0], 2'b00}; // Taken always
			end else begin
				model_pc = model_pc + 32'd4; // No effect
			end
		end
		if (!found) begin
			$display("Reference model found no retiring instruction in 1000 steps");
			errors++;
		end
	endtask

	// Memory responder and retire monitor
	always @(posedge clk) begin
		if (rst_n) begin
			if (ar_valid && ar_ready) begin
				if (first_ar)
					check_addr("first_ar_addr", core_pkg::reset_pc, ar_addr);
				first_ar = 1'b0;
				ar_pending.push_back(ar_addr);
			end
			resp_done = r_valid && r_ready;
			if (resp_done)
				void'(ar_pending.pop_front());
			if (retire_valid) begin
				model_next();
				check_addr("retire_pc", exp_pc, retire_pc);
				check_reg("retire_reg", exp_reg, retire_reg);
				check_word("retire_data", exp_data, retire_data);
				retire_count++;
			end
			#1;
			ar_ready = (next_bits(2) != 0); // Ready three cycles in four
			if (resp_done || !r_valid) begin
				r_valid = 1'b0;
				if (ar_pending.size() != 0 && next_bits(2) != 0) begin
					r_valid = 1'b1;
					r_data = mem[ar_pending[0][7:2]];
					r_resp = axi_pkg::resp_okay;
					if (err_flag[ar_pending[0][7:2]])
						r_resp = (next_bits(1) != 0) ? axi_pkg::resp_slverr : axi_pkg::resp_decerr;
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		r_resp = axi_pkg::resp_okay;
		gen_program();
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk); // State left by reset
		if (ar_valid !== 1'b0 || retire_valid !== 1'b0) begin
			$display("ar_valid or retire_valid not low after reset");
			errors++;
		end
		wait (retire_count >= num_retires);
		$display("%0d check errors, %0d assertion failures, %0d retires",
			errors, dut0.asserts0.fails, retire_count);
		if (errors == 0 && dut0.asserts0.fails == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog, 12 cycles per retire
	initial begin
		#(num_retires * 12 * clk_period);
		$display("Timeout with %0d of %0d retires seen", retire_count, num_retires);
		$display("Something failed");
		$finish;
	end

endmodule

//--- test/core_asserts.sv
`timescale 1ns/10ps

module core_asserts (
	input logic clk,
	input logic rst_n,
	input logic ar_valid,
	input core_pkg::addr_t ar_addr,
	input logic ar_ready,
	input logic r_ready,
	input core_pkg::count_t free_slots
);

	int fails = 0; // Failed assertion count

	// Stalled AR keeps valid and address until accepted
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
	else begin
		$error("AR request dropped or changed before ar_ready");
		fails++;
	end

	// Free slots above depth means the queue count overflowed
	a_queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
		free_slots <= core_pkg::queue_depth)
	else begin
		$error("Instruction queue holds more than queue_depth entries");
		fails++;
	end

	a_r_ready: assert property (@(posedge clk) disable iff (!rst_n) r_ready)
	else begin
		$error("r_ready low out of reset");
		fails++;
	end

endmodule

bind core_top core_asserts asserts0 (
	.clk(clk), .rst_n(rst_n), .ar_valid(ar_valid), .ar_addr(ar_addr),
	.ar_ready(ar_ready), .r_ready(r_ready), .free_slots(free_slots)
);

//--- source/core_top.sv
`timescale 1ns/10ps

module core_top (
	input logic clk,
	input logic rst_n,
	// AXI4-Lite read port
	output logic ar_valid,
	output core_pkg::addr_t ar_addr,
	input logic ar_ready,
	input logic r_valid,
	input core_pkg::word_t r_data,
	input axi_pkg::resp_t r_resp,
	output logic r_ready,
	// Retire port
	output logic retire_valid,
	output core_pkg::addr_t retire_pc,
	output core_pkg::reg_idx_t retire_reg,
	output core_pkg::word_t retire_data
);

	logic push; // Fetch to queue
	core_pkg::word_t push_insn;
	core_pkg::addr_t push_pc;
	core_pkg::count_t free_slots;
	logic head_valid; // Queue to execute
	core_pkg::word_t head_insn;
	core_pkg::addr_t head_pc;
	logic pop;
	logic redirect; // Execute to fetch and queue
	core_pkg::addr_t redirect_pc;
	core_pkg::reg_idx_t rd_a_idx; // Execute to register file
	core_pkg::reg_idx_t rd_b_idx;
	core_pkg::word_t rd_a;
	core_pkg::word_t rd_b;
	logic wr_en;
	core_pkg::reg_idx_t wr_idx;
	core_pkg::word_t wr_data;

	fetch_unit u_fetch (
		.clk(clk), .rst_n(rst_n),
		.ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
		.r_valid(r_valid), .r_data(r_data), .r_resp(r_resp), .r_ready(r_ready),
		.push(push), .push_insn(push_insn), .push_pc(push_pc),
		.free_slots(free_slots),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	insn_queue u_queue (
		.clk(clk), .rst_n(rst_n),
		.push(push), .push_insn(push_insn), .push_pc(push_pc),
		.pop(pop), .flush(redirect), // Branch empties the queue
		.head_valid(head_valid), .head_insn(head_insn), .head_pc(head_pc),
		.free_slots(free_slots)
	);

	reg_file u_rf (
		.clk(clk), .rst_n(rst_n),
		.rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx), .rd_a(rd_a), .rd_b(rd_b),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
	);

	execute_unit u_exec (
		.clk(clk), .rst_n(rst_n),
		.head_valid(head_valid), .head_insn(head_insn), .head_pc(head_pc), .pop(pop),
		.rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx), .rd_a(rd_a), .rd_b(rd_b),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_reg(retire_reg), .retire_data(retire_data)
	);

endmodule

//--- source/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
	input logic clk,
	input logic rst_n,
	// Queue head
	input logic head_valid,
	input core_pkg::word_t head_insn,
	input core_pkg::addr_t head_pc,
	output logic pop,
	// Register file
	output core_pkg::reg_idx_t rd_a_idx,
	output core_pkg::reg_idx_t rd_b_idx,
	input core_pkg::word_t rd_a,
	input core_pkg::word_t rd_b,
	output logic wr_en,
	output core_pkg::reg_idx_t wr_idx,
	output core_pkg::word_t wr_data,
	// Branch redirect
	output logic redirect,
	output core_pkg::addr_t redirect_pc,
	// Retire
	output logic retire_valid,
	output core_pkg::addr_t retire_pc,
	output core_pkg::reg_idx_t retire_reg,
	output core_pkg::word_t retire_data
);

	core_pkg::alu_op_t op; // insn[24:21]
	logic is_dp;
	logic is_branch;
	logic [63:0] imm_dbl; // imm8 twice, so a right shift rotates
	core_pkg::word_t imm_rot;
	core_pkg::word_t operand2;
	core_pkg::word_t result;
	core_pkg::addr_t branch_off;

	assign pop = head_valid; // Single-cycle execute, never stalls

	assign op = core_pkg::alu_op_t'(head_insn[24:21]);
	assign is_dp = head_valid && (head_insn[27:26] == 2'b00)
		&& (op inside {core_pkg::op_and, core_pkg::op_eor, core_pkg::op_sub,
			core_pkg::op_add, core_pkg::op_orr, core_pkg::op_mov});
	assign is_branch = head_valid && (head_insn[27:25] == 3'b101); // Link bit ignored

	assign rd_a_idx = head_insn[19:16]; // Rn
	assign rd_b_idx = head_insn[3:0]; // Rm, no shift applied

	// 8-bit immediate rotated right by 2 * rot
	assign imm_dbl = {2{24'b0, head_insn[7:0]}};
	assign imm_rot = core_pkg::word_t'(imm_dbl >> {head_insn[11:8], 1'b0});
	assign operand2 = head_insn[25] ? imm_rot : rd_b; // I bit picks the form

	always_comb begin
		case (op)
			core_pkg::op_and: result = rd_a & operand2;
			core_pkg::op_eor: result = rd_a ^ operand2;
			core_pkg::op_sub: result = rd_a - operand2;
			core_pkg::op_add: result = rd_a + operand2;
			core_pkg::op_orr: result = rd_a | operand2;
			core_pkg::op_mov: result = operand2; // Rn unused
			default: result = '0;
		endcase
	end

	// Rd written at the end of the pop cycle
	assign wr_en = is_dp;
	assign wr_idx = head_insn[15:12];
	assign wr_data = result;

	// Sign-extended word offset from pc + 8
	assign branch_off = {{6{head_insn[23]}}, head_insn[23:0], 2'b00};
	assign redirect = is_branch;
	assign redirect_pc = head_pc + core_pkg::pc_ahead + branch_off;

	always_ff @(posedge clk) begin
		if (!rst_n)
			retire_valid <= 1'b0;
		else
			retire_valid <= is_dp; // One pulse per data-processing op
	end

	// Retire payload
	always_ff @(posedge clk) begin
		retire_pc <= head_pc;
		retire_reg <= head_insn[15:12];
		retire_data <= result;
	end

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input logic clk,
	input logic rst_n,
	input core_pkg::reg_idx_t rd_a_idx,
	input core_pkg::reg_idx_t rd_b_idx,
	output core_pkg::word_t rd_a,
	output core_pkg::word_t rd_b,
	input logic wr_en,
	input core_pkg::reg_idx_t wr_idx,
	input core_pkg::word_t wr_data
);

	core_pkg::word_t regs [0:15]; // r0..r15, r15 is plain storage here

	assign rd_a = regs[rd_a_idx]; // Combinational reads
	assign rd_b = regs[rd_b_idx];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0; // Architectural state starts at zero
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

//--- source/insn_queue.sv
`timescale 1ns/10ps

module insn_queue (
	input logic clk,
	input logic rst_n,
	input logic push,
	input core_pkg::word_t push_insn,
	input core_pkg::addr_t push_pc,
	input logic pop,
	input logic flush,
	output logic head_valid,
	output core_pkg::word_t head_insn,
	output core_pkg::addr_t head_pc,
	output core_pkg::count_t free_slots
);

	core_pkg::word_t insn_mem [0:core_pkg::queue_depth-1]; // Fetched words
	core_pkg::addr_t pc_mem [0:core_pkg::queue_depth-1]; // Their addresses
	logic [$clog2(core_pkg::queue_depth)-1:0] wr_ptr;
	logic [$clog2(core_pkg::queue_depth)-1:0] rd_ptr;
	core_pkg::count_t count; // Occupied entries
	logic do_push;
	logic do_pop;

	assign do_push = push && !flush; // Push during flush is old path
	assign do_pop = pop && head_valid && !flush;

	assign head_valid = (count != '0);
	assign head_insn = insn_mem[rd_ptr];
	assign head_pc = pc_mem[rd_ptr];
	assign free_slots = core_pkg::count_t'(core_pkg::queue_depth) - count;

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0; // Empty in one cycle
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + core_pkg::count_t'(do_push) - core_pkg::count_t'(do_pop);
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			insn_mem[wr_ptr] <= push_insn;
			pc_mem[wr_ptr] <= push_pc;
		end
	end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
	input logic clk,
	input logic rst_n,
	// AXI4-Lite read master
	output logic ar_valid,
	output core_pkg::addr_t ar_addr,
	input logic ar_ready,
	input logic r_valid,
	input core_pkg::word_t r_data,
	input axi_pkg::resp_t r_resp,
	output logic r_ready,
	// Towards the instruction queue
	output logic push,
	output core_pkg::word_t push_insn,
	output core_pkg::addr_t push_pc,
	input core_pkg::count_t free_slots,
	// Branch redirect from execute
	input logic redirect,
	input core_pkg::addr_t redirect_pc
);

	core_pkg::addr_t pc; // Next address to fetch
	core_pkg::count_t outstanding; // Reads issued, response not yet seen
	core_pkg::count_t discard; // Wrong-path responses still to drop
	core_pkg::addr_t pc_fifo [0:core_pkg::queue_depth-1]; // Pcs of reads in flight
	logic [$clog2(core_pkg::queue_depth)-1:0] wr_ptr;
	logic [$clog2(core_pkg::queue_depth)-1:0] rd_ptr;
	logic ar_fire;
	logic r_fire;
	logic issue;

	assign r_ready = 1'b1; // A queue slot is reserved before every read
	assign ar_fire = ar_valid & ar_ready;
	assign r_fire = r_valid & r_ready;

	// New read only when AR is free and a slot is held for its answer
	assign issue = (!ar_valid || ar_ready) && (outstanding < free_slots) && !redirect;

	// Wrong-path words and error responses are swallowed
	assign push = r_fire && (discard == '0) && (r_resp == axi_pkg::resp_okay);
	assign push_pc = pc_fifo[rd_ptr];
	assign push_insn = r_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= core_pkg::reset_pc;
			ar_valid <= 1'b0;
			outstanding <= '0;
			discard <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (ar_fire)
				ar_valid <= 1'b0; // Handshake done
			if (issue) begin
				ar_valid <= 1'b1; // Overrides the clear above
				pc <= pc + 32'd4;
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (redirect)
				pc <= redirect_pc; // A pending AR keeps its old address
			if (r_fire)
				rd_ptr <= rd_ptr + 1'b1; // Dropped responses still consume a pc
			outstanding <= outstanding + core_pkg::count_t'(issue)
				- core_pkg::count_t'(r_fire);
			// Everything still out after this cycle is wrong path
			if (redirect)
				discard <= outstanding - core_pkg::count_t'(r_fire);
			else if (r_fire && (discard != '0))
				discard <= discard - 1'b1;
		end
	end

	// Address and pc record, no reset needed
	always_ff @(posedge clk) begin
		if (issue) begin
			ar_addr <= pc;
			pc_fifo[wr_ptr] <= pc;
		end
	end

endmodule

//--- source/axi_pkg.sv
package axi_pkg;

	// AXI4-Lite read response
	typedef logic [1:0] resp_t;

	localparam resp_t resp_okay = 2'b00; // Normal access
	localparam resp_t resp_slverr = 2'b10; // Slave error
	localparam resp_t resp_decerr = 2'b11; // Decode error

endpackage

//--- source/core_pkg.sv
package core_pkg;

	// Widths with an architectural meaning
	typedef logic [31:0] word_t; // Data value or instruction word
	typedef logic [31:0] addr_t; // Byte address
	typedef logic [3:0] reg_idx_t; // r0..r15

	// Data processing opcodes, insn[24:21]
	typedef enum logic [3:0] {
		op_and = 4'h0,
		op_eor = 4'h1,
		op_sub = 4'h2,
		op_add = 4'h4,
		op_orr = 4'hc,
		op_mov = 4'hd
	} alu_op_t;

	// Instruction queue sizing
	localparam int queue_depth = 4; // Entries
	typedef logic [2:0] count_t; // Holds 0..queue_depth

	// Program counter constants
	localparam addr_t reset_pc = 32'h0000_0000; // First fetch address
	localparam addr_t pc_ahead = 32'd8; // Branch base is pc + 8, as on ARM

endpackage
